//--- source/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [2:0] {
        IF,
        ID,
        EXE,
        MEM,
        WB
    } cpu_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI   // Passes src2 through
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        br_kind_e    br_kind;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src_reg_is_rd;  // Port 2 reads rd instead of rk
        logic        gr_we;
        logic        mem_we;
        logic        res_from_mem;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [31:0] br_offs;        // Already shifted by two
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]    inst,
    output cpu_pkg::ctrl_t ctrl,
    output logic [4:0]     rj,
    output logic [4:0]     rk,
    output logic [4:0]     rd
);
    import cpu_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        writes_gr;
    logic        dst_is_r1;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.br_kind = BR_NONE;
        ctrl.imm     = {{20{i12[11]}}, i12};
        ctrl.br_offs = {{14{i16[15]}}, i16, 2'b00};
        writes_gr    = 1'b0;
        dst_is_r1    = 1'b0;

        if (op_31_26 == 6'h00 && op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
            writes_gr = 1'b1;  // 3R format
            case (op_19_15)
                5'h00:   ctrl.alu_op = ALU_ADD;
                5'h02:   ctrl.alu_op = ALU_SUB;
                5'h04:   ctrl.alu_op = ALU_SLT;
                5'h05:   ctrl.alu_op = ALU_SLTU;
                5'h08:   ctrl.alu_op = ALU_NOR;
                5'h09:   ctrl.alu_op = ALU_AND;
                5'h0a:   ctrl.alu_op = ALU_OR;
                5'h0b:   ctrl.alu_op = ALU_XOR;
                default: writes_gr   = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
            writes_gr        = 1'b1;
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = {27'b0, inst[14:10]};  // ui5
            case (op_19_15)
                5'h01:   ctrl.alu_op = ALU_SLL;
                5'h09:   ctrl.alu_op = ALU_SRL;
                5'h11:   ctrl.alu_op = ALU_SRA;
                default: writes_gr   = 1'b0;
            endcase
        end else if (op_31_26 == 6'h00 && op_25_22 == 4'ha) begin
            writes_gr        = 1'b1;  // addi.w
            ctrl.src2_is_imm = 1'b1;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h2) begin
            writes_gr         = 1'b1;  // ld.w
            ctrl.src2_is_imm  = 1'b1;
            ctrl.res_from_mem = 1'b1;
        end else if (op_31_26 == 6'h0a && op_25_22 == 4'h6) begin
            ctrl.mem_we        = 1'b1;  // st.w
            ctrl.src2_is_imm   = 1'b1;
            ctrl.src_reg_is_rd = 1'b1;
        end else if (op_31_26 == 6'h05 && !inst[25]) begin
            writes_gr        = 1'b1;  // lu12i.w
            ctrl.alu_op      = ALU_LUI;
            ctrl.src2_is_imm = 1'b1;
            ctrl.imm         = {i20, 12'b0};
        end else begin
            case (op_31_26)
                6'h13: begin
                    writes_gr        = 1'b1;
                    ctrl.br_kind     = BR_JIRL;
                    ctrl.src1_is_pc  = 1'b1;  // Link value pc + 4
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = 32'd4;
                end
                6'h14: begin
                    ctrl.br_kind = BR_B;
                    ctrl.br_offs = {{4{i26[25]}}, i26, 2'b00};
                end
                6'h15: begin
                    writes_gr        = 1'b1;
                    dst_is_r1        = 1'b1;
                    ctrl.br_kind     = BR_BL;
                    ctrl.src1_is_pc  = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = 32'd4;
                    ctrl.br_offs     = {{4{i26[25]}}, i26, 2'b00};
                end
                6'h16: begin
                    ctrl.br_kind       = BR_BEQ;
                    ctrl.src_reg_is_rd = 1'b1;
                end
                6'h17: begin
                    ctrl.br_kind       = BR_BNE;
                    ctrl.src_reg_is_rd = 1'b1;
                end
                default: ;  // Unknown encoding runs as a no-op
            endcase
        end

        ctrl.dest  = dst_is_r1 ? 5'd1 : rd;
        ctrl.gr_we = writes_gr && (ctrl.dest != 5'd0);  // r0 writes are dropped
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  logic [31:0]      src1,
    input  logic [31:0]      src2,
    output logic [31:0]      result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            ALU_LUI:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [31:0];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

//--- source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic             clk,
    input  logic             reset,
    output logic [31:0]      inst_sram_addr,
    input  logic [31:0]      inst_sram_rdata,
    output logic [31:0]      inst,
    input  cpu_pkg::ctrl_t   ctrl,
    input  logic [4:0]       rj,
    input  logic [4:0]       rk,
    input  logic [4:0]       rd,
    output logic [4:0]       rf_raddr1,
    output logic [4:0]       rf_raddr2,
    input  logic [31:0]      rf_rdata1,
    input  logic [31:0]      rf_rdata2,
    output logic             rf_we,
    output logic [4:0]       rf_waddr,
    output logic [31:0]      rf_wdata,
    output cpu_pkg::alu_op_e alu_op,
    output logic [31:0]      alu_src1,
    output logic [31:0]      alu_src2,
    input  logic [31:0]      alu_result,
    output logic             data_sram_we,
    output logic [31:0]      data_sram_addr,
    output logic [31:0]      data_sram_wdata,
    input  logic [31:0]      data_sram_rdata,
    output cpu_pkg::trace_t  trace
);
    import cpu_pkg::*;

    cpu_state_e  state;
    cpu_state_e  next_state;
    logic [31:0] pc;
    logic [31:0] seq_pc;
    ctrl_t       ctrl_q;
    logic [31:0] rj_val;
    logic [31:0] rkd_val;
    logic [31:0] br_target;
    logic [31:0] target;
    logic [31:0] alu_res;
    logic        short_br;   // Branches that retire from ID
    logic        rj_eq_rd;
    logic        br_taken;
    logic        is_link;

    assign inst_sram_addr = pc;
    assign inst           = inst_sram_rdata;  // Valid during ID
    assign seq_pc         = pc + 32'd4;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = ctrl.src_reg_is_rd ? rd : rk;

    assign short_br = (ctrl.br_kind == BR_B) || (ctrl.br_kind == BR_BEQ)
                   || (ctrl.br_kind == BR_BNE);
    assign rj_eq_rd = (rf_rdata1 == rf_rdata2);
    assign br_taken = (ctrl.br_kind == BR_B)
                   || (ctrl.br_kind == BR_BEQ && rj_eq_rd)
                   || (ctrl.br_kind == BR_BNE && !rj_eq_rd);
    assign target   = ((ctrl.br_kind == BR_JIRL) ? rf_rdata1 : pc) + ctrl.br_offs;
    assign is_link  = (ctrl_q.br_kind == BR_BL) || (ctrl_q.br_kind == BR_JIRL);

    always_comb begin
        case (state)
            IF:      next_state = ID;
            ID:      next_state = short_br ? IF : EXE;
            EXE:     next_state = (ctrl_q.mem_we || ctrl_q.res_from_mem) ? MEM : WB;
            MEM:     next_state = ctrl_q.res_from_mem ? WB : IF;
            default: next_state = IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IF;
            pc     <= RESET_PC;
            ctrl_q <= '0;
        end else begin
            state <= next_state;
            case (state)
                ID: begin
                    ctrl_q <= ctrl;
                    if (short_br) pc <= br_taken ? target : seq_pc;
                end
                MEM: if (!ctrl_q.res_from_mem) pc <= seq_pc;  // st.w done
                WB:  pc <= is_link ? br_target : seq_pc;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ID) begin
            rj_val    <= rf_rdata1;
            rkd_val   <= rf_rdata2;
            br_target <= target;
        end
        if (state == EXE) alu_res <= alu_result;
    end

    assign alu_op   = ctrl_q.alu_op;
    assign alu_src1 = ctrl_q.src1_is_pc ? pc : rj_val;
    assign alu_src2 = ctrl_q.src2_is_imm ? ctrl_q.imm : rkd_val;

    assign data_sram_we    = (state == MEM) && ctrl_q.mem_we;
    assign data_sram_addr  = alu_res;
    assign data_sram_wdata = rkd_val;

    assign rf_we    = (state == WB) && ctrl_q.gr_we;
    assign rf_waddr = ctrl_q.dest;
    assign rf_wdata = ctrl_q.res_from_mem ? data_sram_rdata : alu_res;

    assign trace.pc    = pc;
    assign trace.rf_we = {4{rf_we}};
    assign trace.wnum  = rf_waddr;
    assign trace.wdata = rf_wdata;

    // A store occupies one MEM cycle and the next fetch follows at once
    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> (state == MEM) ##1 (state == IF));

    // Writes land in WB and never target r0
    a_write_in_wb: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> (state == WB) && (rf_waddr != 5'd0));

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic [31:0] inst;
    ctrl_t       ctrl;
    logic [4:0]  rj, rk, rd;
    logic [4:0]  rf_raddr1, rf_raddr2, rf_waddr;
    logic [31:0] rf_rdata1, rf_rdata2, rf_wdata;
    logic        rf_we;
    alu_op_e     alu_op;
    logic [31:0] alu_src1, alu_src2, alu_result;
    trace_t      trace;

    inst_decoder u_decoder (.inst(inst), .ctrl(ctrl), .rj(rj), .rk(rk), .rd(rd));

    alu u_alu (.alu_op(alu_op), .src1(alu_src1), .src2(alu_src2), .result(alu_result));

    regfile u_regfile (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    cpu_control #(.RESET_PC(RESET_PC)) u_control (
        .clk(clk), .reset(reset),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .inst(inst), .ctrl(ctrl), .rj(rj), .rk(rk), .rd(rd),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .alu_result(alu_result),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .trace(trace)
    );

    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_we    = trace.rf_we;
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

//--- dv/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
    localparam logic [31:0] M17        = 32'hffff_8000;
    localparam logic [31:0] M10        = 32'hffc0_0000;
    localparam logic [31:0] M7         = 32'hfe00_0000;
    localparam logic [31:0] M6         = 32'hfc00_0000;
    localparam logic [31:0] OP_ADD_W   = 32'h0010_0000;
    localparam logic [31:0] OP_SUB_W   = 32'h0011_0000;
    localparam logic [31:0] OP_SLT     = 32'h0012_0000;
    localparam logic [31:0] OP_SLTU    = 32'h0012_8000;
    localparam logic [31:0] OP_NOR     = 32'h0014_0000;
    localparam logic [31:0] OP_AND     = 32'h0014_8000;
    localparam logic [31:0] OP_OR      = 32'h0015_0000;
    localparam logic [31:0] OP_XOR     = 32'h0015_8000;
    localparam logic [31:0] OP_SLLI_W  = 32'h0040_8000;
    localparam logic [31:0] OP_SRLI_W  = 32'h0044_8000;
    localparam logic [31:0] OP_SRAI_W  = 32'h0048_8000;
    localparam logic [31:0] OP_ADDI_W  = 32'h0280_0000;
    localparam logic [31:0] OP_LD_W    = 32'h2880_0000;
    localparam logic [31:0] OP_ST_W    = 32'h2980_0000;
    localparam logic [31:0] OP_LU12I_W = 32'h1400_0000;
    localparam logic [31:0] OP_JIRL    = 32'h4c00_0000;
    localparam logic [31:0] OP_B       = 32'h5000_0000;  // Also b 0, the final self-loop
    localparam logic [31:0] OP_BL      = 32'h5400_0000;
    localparam logic [31:0] OP_BEQ     = 32'h5800_0000;
    localparam logic [31:0] OP_BNE     = 32'h5c00_0000;
    localparam logic [31:0] OPS_3R [0:7] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
                                             OP_NOR, OP_AND, OP_OR, OP_XOR};

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    typedef struct packed {
        logic        is_store;
        trace_t      tr;
        store_t      st;
        logic [31:0] when;     // Model cycle of the event
    } event_t;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:1023];
    logic [31:0] iaddr_q, daddr_q;
    logic [7:0]  wp;
    logic [31:0] m_pc, m_cyc;
    logic [31:0] m_rf [0:31];
    logic [31:0] m_mem [0:1023];
    event_t      exp_q [$];
    event_t      mon_ev;
    trace_t      act_tr;
    store_t      act_st;
    logic [31:0] cyc, last_cyc, last_when;
    logic        have_last;

    cpu_top #(.RESET_PC(RESET_PC)) dut0 (
        .clk(clk), .reset(reset),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    // Both SRAMs latch the address at the rising edge and answer at the falling edge
    always @(posedge clk) begin
        iaddr_q = inst_sram_addr;
        daddr_q = data_sram_addr;
        if (data_sram_we) dmem[data_sram_addr[11:2]] = data_sram_wdata;
    end

    always @(negedge clk) begin
        inst_sram_rdata = imem_word(iaddr_q);
        data_sram_rdata = dmem[daddr_q[11:2]];
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        report_error($sformatf("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) report_value(name, exp, act);
    endtask

    task automatic check_trace(input trace_t exp, input trace_t act);
        if (act.pc !== exp.pc) report_value("debug_wb_pc", exp.pc, act.pc);
        else if (act.rf_we !== exp.rf_we)
            report_value("debug_wb_rf_we", {28'h0, exp.rf_we}, {28'h0, act.rf_we});
        else if (act.wnum !== exp.wnum)
            report_value("debug_wb_rf_wnum", {27'h0, exp.wnum}, {27'h0, act.wnum});
        else if (act.wdata !== exp.wdata) report_value("debug_wb_rf_wdata", exp.wdata, act.wdata);
    endtask

    task automatic check_store(input store_t exp, input store_t act);
        if (act.addr !== exp.addr) report_value("data_sram_addr", exp.addr, act.addr);
        else if (act.data !== exp.data) report_value("data_sram_wdata", exp.data, act.data);
    endtask

    function automatic logic [31:0] imem_word(input logic [31:0] a);
        logic [31:0] off;
        off = a - RESET_PC;
        if (off[31:10] != 22'h0) return 32'h0;  // Outside the program, a no-op
        return imem[off[9:2]];
    endfunction

    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return {idx, 22'h0} ^ {22'h0, ~idx} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [4:0] rand_src();
        logic [31:0] r;
        r = $urandom;
        return 5'd4 + {2'b00, r[2:0]};  // r4 to r11 hold the random operands
    endfunction

    function automatic logic [31:0] enc_3r(input logic [31:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return op | {17'h0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [31:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [11:0] imm);
        return op | {10'h0, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] imm);
        return OP_LU12I_W | {7'h0, imm, rd};
    endfunction

    function automatic logic [31:0] enc_br16(input logic [31:0] op, input logic [4:0] rj,
                                             input logic [4:0] rd, input logic [15:0] offs);
        return op | {6'h0, offs, rj, rd};  // Offset in words
    endfunction

    function automatic logic [31:0] enc_b26(input logic [31:0] op, input logic [25:0] offs);
        return op | {6'h0, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[wp] = w;
        wp = wp + 8'd1;
    endtask

    // Architectural model, one instruction per call; returns 1 when the step has a visible event
    function automatic logic model_step(output event_t ev);
        logic [31:0] inst, vj, vk, vd, res, si12, offs16, offs26, addr, nxt;
        logic [4:0]  wreg;
        logic [2:0]  ncyc;
        logic        wr;
        logic        st;
        inst   = imem_word(m_pc);
        vj     = m_rf[inst[9:5]];
        vk     = m_rf[inst[14:10]];
        vd     = m_rf[inst[4:0]];
        si12   = {{20{inst[21]}}, inst[21:10]};
        offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        addr   = vj + si12;
        res    = 32'h0;
        wr     = 1'b1;
        st     = 1'b0;
        wreg   = inst[4:0];
        ncyc   = 3'd4;
        nxt    = m_pc + 32'd4;
        ev     = '0;
        if ((inst & M17) == OP_ADD_W) res = vj + vk;
        else if ((inst & M17) == OP_SUB_W) res = vj - vk;
        else if ((inst & M17) == OP_SLT) res = {31'h0, (vj ^ 32'h8000_0000) < (vk ^ 32'h8000_0000)};
        else if ((inst & M17) == OP_SLTU) res = {31'h0, vj < vk};
        else if ((inst & M17) == OP_NOR) res = ~vj & ~vk;
        else if ((inst & M17) == OP_AND) res = vj & vk;
        else if ((inst & M17) == OP_OR) res = vj | vk;
        else if ((inst & M17) == OP_XOR) res = vj ^ vk;
        else if ((inst & M17) == OP_SLLI_W) res = vj << inst[14:10];
        else if ((inst & M17) == OP_SRLI_W) res = vj >> inst[14:10];
        else if ((inst & M17) == OP_SRAI_W)
            res = (vj >> inst[14:10]) | (~(32'hffff_ffff >> inst[14:10]) & {32{vj[31]}});
        else if ((inst & M10) == OP_ADDI_W) res = addr;
        else if ((inst & M10) == OP_LD_W) begin
            res  = m_mem[addr[11:2]];
            ncyc = 3'd5;
        end else if ((inst & M10) == OP_ST_W) begin
            wr = 1'b0;
            st = 1'b1;
            m_mem[addr[11:2]] = vd;
        end else if ((inst & M7) == OP_LU12I_W) res = {inst[24:5], 12'h000};
        else if ((inst & M6) == OP_JIRL) begin
            res = m_pc + 32'd4;
            nxt = vj + offs16;
        end else if ((inst & M6) == OP_B) begin
            wr   = 1'b0;
            ncyc = 3'd2;
            nxt  = m_pc + offs26;
        end else if ((inst & M6) == OP_BL) begin
            res  = m_pc + 32'd4;
            wreg = 5'd1;
            nxt  = m_pc + offs26;
        end else if ((inst & M6) == OP_BEQ || (inst & M6) == OP_BNE) begin
            wr   = 1'b0;
            ncyc = 3'd2;
            if ((vj == vd) == ((inst & M6) == OP_BEQ)) nxt = m_pc + offs16;
        end else wr = 1'b0;  // Unknown encoding

        if (st) begin
            ev.is_store = 1'b1;
            ev.st.addr  = addr;
            ev.st.data  = vd;
            ev.when     = m_cyc + 32'd3;
        end else if (wr && wreg != 5'd0) begin
            ev.tr.pc    = m_pc;
            ev.tr.rf_we = 4'hf;
            ev.tr.wnum  = wreg;
            ev.tr.wdata = res;
            ev.when     = m_cyc + {29'h0, ncyc} - 32'd1;
            m_rf[wreg]  = res;
        end
        m_cyc = m_cyc + {29'h0, ncyc};
        m_pc  = nxt;
        return st || (wr && wreg != 5'd0);
    endfunction

    // Compare every DUT write or store with the next model event, spacing included
    always @(posedge clk) begin
        if (reset) begin
            cyc       = 32'h0;
            have_last = 1'b0;
        end else begin
            cyc = cyc + 32'd1;
            if (debug_wb_rf_we != 4'h0 || data_sram_we) begin
                if (exp_q.size() == 0) begin
                    report_error($sformatf("ERROR at %0t: DUT event after the model ran out", $time));
                end else begin
                    mon_ev = exp_q.pop_front();
                    if (mon_ev.is_store != data_sram_we) begin
                        report_error($sformatf("ERROR at %0t: event kind differs, store expected %0b",
                                               $time, mon_ev.is_store));
                    end else if (mon_ev.is_store) begin
                        act_st.addr = data_sram_addr;
                        act_st.data = data_sram_wdata;
                        check_store(mon_ev.st, act_st);
                    end else begin
                        act_tr.pc    = debug_wb_pc;
                        act_tr.rf_we = debug_wb_rf_we;
                        act_tr.wnum  = debug_wb_rf_wnum;
                        act_tr.wdata = debug_wb_rf_wdata;
                        check_trace(mon_ev.tr, act_tr);
                    end
                    if (have_last && (cyc - last_cyc) != (mon_ev.when - last_when))
                        report_value("event spacing", mon_ev.when - last_when, cyc - last_cyc);
                    last_cyc  = cyc;
                    last_when = mon_ev.when;
                    have_last = 1'b1;
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] final_pc;
        event_t      ev;
        int          steps;
        int          waited;
        void'($urandom(32'h68e66050));
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        iaddr_q         = RESET_PC;
        daddr_q         = 32'h0;
        wp              = 8'h0;
        m_pc            = RESET_PC;
        m_cyc           = 32'h0;
        for (int i = 0; i < 256; i++) imem[i[7:0]] = 32'h0;
        for (int i = 0; i < 32; i++) m_rf[i[4:0]] = 32'h0;
        for (int i = 0; i < 1024; i++) begin
            dmem[i[9:0]]  = fill_word(i[9:0]);
            m_mem[i[9:0]] = fill_word(i[9:0]);
        end

        for (int i = 4; i < 12; i++) begin  // Random operands
            rnd = $urandom;
            emit(enc_lu12i(i[4:0], rnd[31:12]));
            emit(enc_i12(OP_ADDI_W, i[4:0], i[4:0], rnd[11:0]));
        end
        emit(enc_3r(OP_XOR, 5'd4, 5'd4, 5'd9));
        emit(enc_3r(OP_XOR, 5'd7, 5'd7, 5'd10));
        for (int k = 0; k < 16; k++)
            emit(enc_3r(OPS_3R[k[2:0]], 5'd12 + {2'b00, k[2:0]}, rand_src(), rand_src()));
        rnd = $urandom;
        emit(enc_i12(OP_ADDI_W, 5'd20, rand_src(), rnd[11:0]));
        emit(enc_3r(OP_SLLI_W, 5'd21, rand_src(), rnd[16:12]));
        emit(enc_3r(OP_SRLI_W, 5'd22, rand_src(), rnd[21:17]));
        emit(enc_3r(OP_SRAI_W, 5'd23, rand_src(), rnd[26:22]));
        emit(enc_lu12i(5'd24, rnd[31:12]));
        emit(enc_3r(OP_SRAI_W, 5'd23, 5'd24, rnd[4:0]));
        emit(32'h0);                                       // Unknown encoding
        emit(enc_3r(OP_ADD_W, 5'd0, 5'd4, 5'd5));          // r0 stays zero
        emit(enc_i12(OP_ADDI_W, 5'd0, 5'd6, 12'h123));
        emit(enc_3r(OP_ADD_W, 5'd25, 5'd0, 5'd7));
        emit(enc_lu12i(5'd26, 20'h1c080));                 // Data base
        emit(enc_i12(OP_ST_W, 5'd4, 5'd26, 12'h010));
        emit(enc_i12(OP_ST_W, 5'd5, 5'd26, 12'hff8));
        emit(enc_i12(OP_LD_W, 5'd27, 5'd26, 12'h010));
        emit(enc_i12(OP_LD_W, 5'd28, 5'd26, 12'hff8));
        emit(enc_br16(OP_BEQ, 5'd4, 5'd4, 16'd2));
        emit(enc_i12(OP_ADDI_W, 5'd29, 5'd0, 12'd1));
        emit(enc_br16(OP_BEQ, 5'd4, 5'd5, 16'd2));
        emit(enc_i12(OP_ADDI_W, 5'd29, 5'd0, 12'd2));
        emit(enc_br16(OP_BNE, 5'd4, 5'd5, 16'd2));
        emit(enc_i12(OP_ADDI_W, 5'd29, 5'd0, 12'd3));
        emit(enc_br16(OP_BNE, 5'd6, 5'd6, 16'd2));
        emit(enc_i12(OP_ADDI_W, 5'd29, 5'd0, 12'd4));
        emit(enc_b26(OP_B, 26'd2));
        emit(enc_i12(OP_ADDI_W, 5'd30, 5'd0, 12'd5));
        emit(enc_b26(OP_BL, 26'd2));
        emit(enc_i12(OP_ADDI_W, 5'd30, 5'd0, 12'd6));      // r1 points here
        emit(enc_br16(OP_JIRL, 5'd1, 5'd31, 16'd3));
        emit(enc_i12(OP_ADDI_W, 5'd30, 5'd0, 12'd7));
        emit(enc_3r(OP_ADD_W, 5'd2, 5'd1, 5'd31));
        emit(enc_i12(OP_ADDI_W, 5'd3, 5'd0, 12'd3));       // Short backward loop
        emit(enc_i12(OP_ADDI_W, 5'd3, 5'd3, 12'hfff));
        emit(enc_br16(OP_BNE, 5'd3, 5'd0, 16'hffff));
        emit(OP_B);

        steps = 0;
        while (imem_word(m_pc) != OP_B && steps < 1000) begin
            if (model_step(ev)) exp_q.push_back(ev);
            steps++;
        end
        final_pc = m_pc;

        repeat (3) begin
            @(negedge clk);
            check_word("data_sram_we", 32'h0, {31'h0, data_sram_we});
            check_word("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        end
        reset = 1'b0;
        check_word("inst_sram_addr", RESET_PC, inst_sram_addr);
        check_word("data_sram_we", 32'h0, {31'h0, data_sram_we});
        check_word("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});

        waited = 0;
        while ((exp_q.size() != 0 || inst_sram_addr != final_pc) && waited < 4000) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || inst_sram_addr != final_pc) begin
            report_error($sformatf("ERROR: timeout with %0d events unmatched, pc %h",
                                   exp_q.size(), inst_sram_addr));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- vlog.f
source/cpu_pkg.sv
source/inst_decoder.sv
source/alu.sv
source/regfile.sv
source/cpu_control.sv
source/cpu_top.sv
dv/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module tb_cpu -f vlog.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1
